// File: lisp_pkg.sv
package lisp_pkg;

	// Data word, top of stack and memory value
	typedef logic [15:0] word_t;

	// Instruction or data address
	typedef logic [15:0] addr_t;

	// Opcode in the upper five bits, immediate below
	typedef logic [20:0] instr_t;

	// Signed branch offset or push value
	typedef logic [15:0] imm_t;

	// Unlisted encodings (calls, tag handling) run as NOP
	typedef enum logic [4:0] {
		OP_NOP    = 5'd0,
		OP_POP    = 5'd3,
		OP_LOAD   = 5'd4,
		OP_STORE  = 5'd5,
		OP_ADD    = 5'd6,
		OP_SUB    = 5'd7,
		OP_GTR    = 5'd9,
		OP_GTE    = 5'd10,
		OP_EQ     = 5'd11,
		OP_NEQ    = 5'd12,
		OP_DUP    = 5'd13,
		OP_AND    = 5'd16,
		OP_OR     = 5'd17,
		OP_XOR    = 5'd18,
		OP_LSHIFT = 5'd19,
		OP_RSHIFT = 5'd20,
		OP_PUSH   = 5'd25,
		OP_GOTO   = 5'd26,
		OP_BFALSE = 5'd27
	} opcode_t;

	typedef enum logic [2:0] {
		STATE_START,
		STATE_DECODE,
		STATE_GOT_NOS,
		STATE_GOT_STORE_VALUE,
		STATE_POP_RESULT,
		STATE_BFALSE2
	} state_t;

	typedef enum logic [1:0] {SP_CURRENT, SP_DECREMENT, SP_INCREMENT} sp_sel_t;

	typedef enum logic [1:0] {
		TOS_CURRENT,
		TOS_PARAM,
		TOS_ALU_RESULT,
		TOS_MEMORY_RESULT
	} tos_sel_t;

	typedef enum logic [1:0] {
		MA_STACK_POINTER,
		MA_TOP_OF_STACK,
		MA_STACK_POINTER_MINUS_ONE
	} ma_sel_t;

	typedef enum logic [1:0] {MW_TOP_OF_STACK, MW_MEM_READ_RESULT} mw_sel_t;

	typedef enum logic [1:0] {IP_CURRENT, IP_NEXT, IP_BRANCH_TARGET} ip_sel_t;

	localparam int DATA_MEM_SIZE = 8192;

	// Stack starts a few words below the end of data memory
	localparam addr_t STACK_RESET = addr_t'(DATA_MEM_SIZE - 8);

	// First NEXT wraps this to address 0
	localparam addr_t IP_RESET = 16'hffff;

endpackage

// File: stack_alu.sv
module stack_alu (
	input  lisp_pkg::opcode_t alu_op,
	input  logic              addr_mode,
	input  lisp_pkg::word_t   op0,
	input  lisp_pkg::word_t   op1,
	output lisp_pkg::word_t   result
);

	lisp_pkg::word_t diff;
	logic            zero;
	logic            negative;

	// One subtractor serves SUB and all four comparisons
	assign diff = op0 - op1;
	assign zero = (diff == '0);
	assign negative = diff[15];

	always_comb
	begin
		if (addr_mode)
		begin
			// Stack pointer minus one for pushes
			result = op0 - 16'd1;
		end
		else
		begin
			case (alu_op)
				lisp_pkg::OP_ADD:    result = op0 + op1;
				lisp_pkg::OP_SUB:    result = diff;
				lisp_pkg::OP_GTR:    result = {15'd0, !negative && !zero};
				lisp_pkg::OP_GTE:    result = {15'd0, !negative};
				lisp_pkg::OP_EQ:     result = {15'd0, zero};
				lisp_pkg::OP_NEQ:    result = {15'd0, !zero};
				lisp_pkg::OP_AND:    result = op0 & op1;
				lisp_pkg::OP_OR:     result = op0 | op1;
				lisp_pkg::OP_XOR:    result = op0 ^ op1;
				lisp_pkg::OP_LSHIFT: result = op0 << op1;
				lisp_pkg::OP_RSHIFT: result = op0 >> op1;
				default:             result = diff;
			endcase
		end
	end

endmodule

// File: core_control.sv
module core_control (
	input  logic               clk,
	input  logic               rst_n,
	input  lisp_pkg::opcode_t  opcode,
	input  logic               tos_zero,
	output lisp_pkg::sp_sel_t  sp_sel,
	output lisp_pkg::tos_sel_t tos_sel,
	output lisp_pkg::ma_sel_t  ma_sel,
	output lisp_pkg::mw_sel_t  mw_sel,
	output lisp_pkg::ip_sel_t  ip_sel,
	output lisp_pkg::opcode_t  alu_op,
	output logic               alu_addr_mode,
	output logic               data_write_enable
);

	lisp_pkg::state_t state;
	lisp_pkg::state_t state_next;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= lisp_pkg::STATE_START;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next = state;
		sp_sel = lisp_pkg::SP_CURRENT;
		tos_sel = lisp_pkg::TOS_CURRENT;
		ma_sel = lisp_pkg::MA_STACK_POINTER;
		mw_sel = lisp_pkg::MW_TOP_OF_STACK;
		ip_sel = lisp_pkg::IP_CURRENT;
		alu_op = opcode;
		alu_addr_mode = 1'b0;
		data_write_enable = 1'b0;

		case (state)
			lisp_pkg::STATE_START:
			begin
				// Fetch address 0 and start decoding
				ip_sel = lisp_pkg::IP_NEXT;
				state_next = lisp_pkg::STATE_DECODE;
			end

			lisp_pkg::STATE_DECODE:
			begin
				case (opcode)
					lisp_pkg::OP_PUSH,
					lisp_pkg::OP_DUP:
					begin
						// Spill TOS to SP-1 and move the stack down
						alu_addr_mode = 1'b1;
						ma_sel = lisp_pkg::MA_STACK_POINTER_MINUS_ONE;
						mw_sel = lisp_pkg::MW_TOP_OF_STACK;
						data_write_enable = 1'b1;
						sp_sel = lisp_pkg::SP_DECREMENT;
						if (opcode == lisp_pkg::OP_PUSH)
							tos_sel = lisp_pkg::TOS_PARAM;
						ip_sel = lisp_pkg::IP_NEXT;
					end

					lisp_pkg::OP_POP:
					begin
						sp_sel = lisp_pkg::SP_INCREMENT;
						state_next = lisp_pkg::STATE_POP_RESULT;
					end

					lisp_pkg::OP_LOAD:
					begin
						ma_sel = lisp_pkg::MA_TOP_OF_STACK;
						state_next = lisp_pkg::STATE_POP_RESULT;
					end

					lisp_pkg::OP_STORE:
					begin
						// NOS is the value, TOS the address
						state_next = lisp_pkg::STATE_GOT_STORE_VALUE;
					end

					lisp_pkg::OP_ADD,
					lisp_pkg::OP_SUB,
					lisp_pkg::OP_GTR,
					lisp_pkg::OP_GTE,
					lisp_pkg::OP_EQ,
					lisp_pkg::OP_NEQ,
					lisp_pkg::OP_AND,
					lisp_pkg::OP_OR,
					lisp_pkg::OP_XOR,
					lisp_pkg::OP_LSHIFT,
					lisp_pkg::OP_RSHIFT:
					begin
						// Instruction is refetched so the opcode stays valid
						state_next = lisp_pkg::STATE_GOT_NOS;
					end

					lisp_pkg::OP_GOTO:
						ip_sel = lisp_pkg::IP_BRANCH_TARGET;

					lisp_pkg::OP_BFALSE:
					begin
						if (tos_zero)
							ip_sel = lisp_pkg::IP_BRANCH_TARGET;
						else
							ip_sel = lisp_pkg::IP_NEXT;
						// Condition consumed, reload TOS from NOS
						sp_sel = lisp_pkg::SP_INCREMENT;
						state_next = lisp_pkg::STATE_BFALSE2;
					end

					default:
						ip_sel = lisp_pkg::IP_NEXT;
				endcase
			end

			lisp_pkg::STATE_GOT_NOS:
			begin
				tos_sel = lisp_pkg::TOS_ALU_RESULT;
				sp_sel = lisp_pkg::SP_INCREMENT;
				ip_sel = lisp_pkg::IP_NEXT;
				state_next = lisp_pkg::STATE_DECODE;
			end

			lisp_pkg::STATE_GOT_STORE_VALUE:
			begin
				// Write NOS to mem[TOS], NOS stays as the new TOS
				data_write_enable = 1'b1;
				ma_sel = lisp_pkg::MA_TOP_OF_STACK;
				mw_sel = lisp_pkg::MW_MEM_READ_RESULT;
				tos_sel = lisp_pkg::TOS_MEMORY_RESULT;
				sp_sel = lisp_pkg::SP_INCREMENT;
				ip_sel = lisp_pkg::IP_NEXT;
				state_next = lisp_pkg::STATE_DECODE;
			end

			lisp_pkg::STATE_POP_RESULT:
			begin
				tos_sel = lisp_pkg::TOS_MEMORY_RESULT;
				ip_sel = lisp_pkg::IP_NEXT;
				state_next = lisp_pkg::STATE_DECODE;
			end

			lisp_pkg::STATE_BFALSE2:
			begin
				// IP already holds the target, refetch it
				tos_sel = lisp_pkg::TOS_MEMORY_RESULT;
				state_next = lisp_pkg::STATE_DECODE;
			end

			default:
				state_next = lisp_pkg::STATE_START;
		endcase
	end

	// No memory write may come out of reset before the first decode
	assert property (@(posedge clk) state == lisp_pkg::STATE_START |-> !data_write_enable);

	assert property (@(posedge clk) disable iff (!rst_n)
		state inside {lisp_pkg::STATE_START, lisp_pkg::STATE_DECODE,
			lisp_pkg::STATE_GOT_NOS, lisp_pkg::STATE_GOT_STORE_VALUE,
			lisp_pkg::STATE_POP_RESULT, lisp_pkg::STATE_BFALSE2});

endmodule

// File: core_datapath.sv
module core_datapath (
	input  logic               clk,
	input  logic               rst_n,
	input  lisp_pkg::instr_t   instr_read_value,
	input  lisp_pkg::word_t    data_read_value,
	input  lisp_pkg::sp_sel_t  sp_sel,
	input  lisp_pkg::tos_sel_t tos_sel,
	input  lisp_pkg::ma_sel_t  ma_sel,
	input  lisp_pkg::mw_sel_t  mw_sel,
	input  lisp_pkg::ip_sel_t  ip_sel,
	input  lisp_pkg::word_t    alu_result,
	output lisp_pkg::opcode_t  opcode,
	output lisp_pkg::word_t    alu_op0,
	output lisp_pkg::word_t    alu_op1,
	output logic               tos_zero,
	output lisp_pkg::addr_t    instr_address,
	output lisp_pkg::addr_t    data_address,
	output lisp_pkg::word_t    data_write_value
);

	lisp_pkg::addr_t instruction_pointer;
	lisp_pkg::addr_t ip_next;
	lisp_pkg::addr_t stack_pointer;
	lisp_pkg::addr_t sp_next;
	lisp_pkg::word_t top_of_stack;
	lisp_pkg::word_t tos_next;
	lisp_pkg::imm_t  imm;
	lisp_pkg::addr_t branch_target;

	assign opcode = lisp_pkg::opcode_t'(instr_read_value[20:16]);
	assign imm = instr_read_value[15:0];

	// Offset is relative to the branch instruction itself
	assign branch_target = instruction_pointer + imm;

	assign tos_zero = (top_of_stack == '0);

	// Pushes run the stack pointer through the ALU for SP-1
	assign alu_op0 = (ma_sel == lisp_pkg::MA_STACK_POINTER_MINUS_ONE) ?
		stack_pointer : top_of_stack;
	assign alu_op1 = data_read_value;

	always_comb
	begin
		case (ip_sel)
			lisp_pkg::IP_NEXT:          ip_next = instruction_pointer + 16'd1;
			lisp_pkg::IP_BRANCH_TARGET: ip_next = branch_target;
			default:                    ip_next = instruction_pointer;
		endcase
	end

	// Fetch address leads the IP register by one cycle
	assign instr_address = ip_next;

	always_comb
	begin
		case (sp_sel)
			lisp_pkg::SP_DECREMENT: sp_next = alu_result;
			lisp_pkg::SP_INCREMENT: sp_next = stack_pointer + 16'd1;
			default:                sp_next = stack_pointer;
		endcase
	end

	always_comb
	begin
		case (tos_sel)
			lisp_pkg::TOS_PARAM:         tos_next = imm;
			lisp_pkg::TOS_ALU_RESULT:    tos_next = alu_result;
			lisp_pkg::TOS_MEMORY_RESULT: tos_next = data_read_value;
			default:                     tos_next = top_of_stack;
		endcase
	end

	always_comb
	begin
		case (ma_sel)
			lisp_pkg::MA_TOP_OF_STACK:            data_address = top_of_stack;
			lisp_pkg::MA_STACK_POINTER_MINUS_ONE: data_address = alu_result;
			default:                              data_address = stack_pointer;
		endcase
	end

	// STORE writes back the NOS that was just read
	assign data_write_value = (mw_sel == lisp_pkg::MW_MEM_READ_RESULT) ?
		data_read_value : top_of_stack;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			instruction_pointer <= lisp_pkg::IP_RESET;
			stack_pointer <= lisp_pkg::STACK_RESET;
		end
		else
		begin
			instruction_pointer <= ip_next;
			stack_pointer <= sp_next;
		end
	end

	always_ff @(posedge clk)
	begin
		top_of_stack <= tos_next;
	end

	// Catches popping past the stack base
	assert property (@(posedge clk) disable iff (!rst_n)
		stack_pointer <= lisp_pkg::addr_t'(lisp_pkg::DATA_MEM_SIZE));

endmodule

// File: lisp_core.sv
module lisp_core (
	input  logic             clk,
	input  logic             rst_n,
	output lisp_pkg::addr_t  instr_address,
	input  lisp_pkg::instr_t instr_read_value,
	output lisp_pkg::addr_t  data_address,
	input  lisp_pkg::word_t  data_read_value,
	output lisp_pkg::word_t  data_write_value,
	output logic             data_write_enable
);

	lisp_pkg::opcode_t  opcode;
	lisp_pkg::opcode_t  alu_op;
	lisp_pkg::sp_sel_t  sp_sel;
	lisp_pkg::tos_sel_t tos_sel;
	lisp_pkg::ma_sel_t  ma_sel;
	lisp_pkg::mw_sel_t  mw_sel;
	lisp_pkg::ip_sel_t  ip_sel;
	logic               alu_addr_mode;
	logic               tos_zero;
	lisp_pkg::word_t    alu_op0;
	lisp_pkg::word_t    alu_op1;
	lisp_pkg::word_t    alu_result;

	core_control i_core_control (
		.clk               (clk),
		.rst_n             (rst_n),
		.opcode            (opcode),
		.tos_zero          (tos_zero),
		.sp_sel            (sp_sel),
		.tos_sel           (tos_sel),
		.ma_sel            (ma_sel),
		.mw_sel            (mw_sel),
		.ip_sel            (ip_sel),
		.alu_op            (alu_op),
		.alu_addr_mode     (alu_addr_mode),
		.data_write_enable (data_write_enable)
	);

	core_datapath i_core_datapath (
		.clk              (clk),
		.rst_n            (rst_n),
		.instr_read_value (instr_read_value),
		.data_read_value  (data_read_value),
		.sp_sel           (sp_sel),
		.tos_sel          (tos_sel),
		.ma_sel           (ma_sel),
		.mw_sel           (mw_sel),
		.ip_sel           (ip_sel),
		.alu_result       (alu_result),
		.opcode           (opcode),
		.alu_op0          (alu_op0),
		.alu_op1          (alu_op1),
		.tos_zero         (tos_zero),
		.instr_address    (instr_address),
		.data_address     (data_address),
		.data_write_value (data_write_value)
	);

	stack_alu i_stack_alu (
		.alu_op    (alu_op),
		.addr_mode (alu_addr_mode),
		.op0       (alu_op0),
		.op1       (alu_op1),
		.result    (alu_result)
	);

endmodule

// File: tb_memory.sv
module tb_memory (
	input  logic             clk,
	input  lisp_pkg::addr_t  instr_address,
	output lisp_pkg::instr_t instr_read_value,
	input  lisp_pkg::addr_t  data_address,
	output lisp_pkg::word_t  data_read_value,
	input  lisp_pkg::word_t  data_write_value,
	input  logic             data_write_enable
);

	timeunit 1ns;
	timeprecision 1ps;

	// Test programs are short, 1024 instruction words are plenty
	lisp_pkg::instr_t instr_mem [0:1023];
	lisp_pkg::word_t  data_mem [0:lisp_pkg::DATA_MEM_SIZE-1];

	// Untouched data words hold a pattern of their own address
	function automatic lisp_pkg::word_t data_fill(input lisp_pkg::addr_t address);
		return address ^ 16'ha5c3;
	endfunction

	// Unused instruction slots are NOPs carrying their address as immediate
	task automatic fill_memories();
		for (int i = 0; i < 1024; i++)
			instr_mem[i] = {lisp_pkg::OP_NOP, 16'(i)};
		for (int i = 0; i < lisp_pkg::DATA_MEM_SIZE; i++)
			data_mem[i] = data_fill(16'(i));
	endtask

	task automatic load_instr(input lisp_pkg::addr_t address, input lisp_pkg::instr_t instr);
		instr_mem[address[9:0]] = instr;
	endtask

	task automatic peek_data(input lisp_pkg::addr_t address, output lisp_pkg::word_t value);
		value = data_mem[address[12:0]];
	endtask

	initial
	begin
		instr_read_value = '0;
		data_read_value = '0;
		fill_memories();
	end

	// Address in one cycle, read value in the next
	always @(posedge clk)
	begin
		instr_read_value <= instr_mem[instr_address[9:0]];
		data_read_value <= data_mem[data_address[12:0]];
		if (data_write_enable)
			data_mem[data_address[12:0]] <= data_write_value;
	end

endmodule

// File: tb_lisp_core.sv
module tb_lisp_core;

	timeunit 1ns;
	timeprecision 1ps;

	logic             clk;
	logic             rst_n;
	lisp_pkg::addr_t  instr_address;
	lisp_pkg::instr_t instr_read_value;
	lisp_pkg::addr_t  data_address;
	lisp_pkg::word_t  data_read_value;
	lisp_pkg::word_t  data_write_value;
	logic             data_write_enable;

	lisp_pkg::instr_t program_q [$];
	int               error_count;
	int               tests_run;
	int               tests_failed;

	lisp_core i_lisp_core (
		.clk               (clk),
		.rst_n             (rst_n),
		.instr_address     (instr_address),
		.instr_read_value  (instr_read_value),
		.data_address      (data_address),
		.data_read_value   (data_read_value),
		.data_write_value  (data_write_value),
		.data_write_enable (data_write_enable)
	);

	tb_memory i_tb_memory (
		.clk               (clk),
		.instr_address     (instr_address),
		.instr_read_value  (instr_read_value),
		.data_address      (data_address),
		.data_read_value   (data_read_value),
		.data_write_value  (data_write_value),
		.data_write_enable (data_write_enable)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s: got %0h, expected %0h", name, actual, expected);
			error_count++;
		end
	endtask

	task automatic report_test(input string name, input int start_errors);
		tests_run++;
		if (error_count == start_errors)
			$display("%s: passed", name);
		else
		begin
			tests_failed++;
			$display("%s: FAILED with %0d errors", name, error_count - start_errors);
		end
	endtask

	task automatic emit(input lisp_pkg::opcode_t op, input lisp_pkg::imm_t imm);
		program_q.push_back({op, imm});
	endtask

	// Reset goes low first so the old program cannot run while memory is reloaded
	task automatic load_and_hold_reset();
		@(posedge clk);
		rst_n <= 1'b0;
		i_tb_memory.fill_memories();
		for (int i = 0; i < program_q.size(); i++)
			i_tb_memory.load_instr(lisp_pkg::addr_t'(i), program_q[i]);
	endtask

	task automatic release_reset();
		for (int i = 0; i < 8; i++)
		begin
			@(negedge clk);
			check_value("data_write_enable during reset", data_write_enable, 0);
			@(posedge clk);
		end
		rst_n <= 1'b1;
	endtask

	// Closing GOTO 0 keeps the fetch address fixed
	task automatic wait_for_loop(input string name);
		lisp_pkg::addr_t last_address;
		int              stable_cycles;
		int              cycles;
		stable_cycles = 0;
		cycles = 0;
		@(negedge clk);
		last_address = instr_address;
		while (stable_cycles < 4 && cycles < 2000)
		begin
			@(negedge clk);
			cycles++;
			if (instr_address == last_address)
				stable_cycles++;
			else
				stable_cycles = 0;
			last_address = instr_address;
		end
		if (stable_cycles < 4)
		begin
			$display("%s: the core never reached its closing loop", name);
			error_count++;
		end
	endtask

	task automatic run_program(input string name);
		load_and_hold_reset();
		release_reset();
		wait_for_loop(name);
	endtask

	task automatic check_memory(input lisp_pkg::addr_t address, input lisp_pkg::word_t expected);
		lisp_pkg::word_t got;
		i_tb_memory.peek_data(address, got);
		check_value($sformatf("mem[%h]", address), got, expected);
	endtask

	function automatic lisp_pkg::word_t expected_alu(input lisp_pkg::opcode_t op,
		input lisp_pkg::word_t tos, input lisp_pkg::word_t nos);
		lisp_pkg::word_t diff;
		diff = tos - nos;
		case (op)
			lisp_pkg::OP_ADD:    return tos + nos;
			lisp_pkg::OP_SUB:    return diff;
			lisp_pkg::OP_GTR:    return (diff != 16'd0 && !diff[15]) ? 16'd1 : 16'd0;
			lisp_pkg::OP_GTE:    return !diff[15] ? 16'd1 : 16'd0;
			lisp_pkg::OP_EQ:     return (tos == nos) ? 16'd1 : 16'd0;
			lisp_pkg::OP_NEQ:    return (tos != nos) ? 16'd1 : 16'd0;
			lisp_pkg::OP_AND:    return tos & nos;
			lisp_pkg::OP_OR:     return tos | nos;
			lisp_pkg::OP_XOR:    return tos ^ nos;
			lisp_pkg::OP_LSHIFT: return tos << nos;
			lisp_pkg::OP_RSHIFT: return tos >> nos;
			default:             return 16'd0;
		endcase
	endfunction

	task automatic run_reset_test();
		int start_errors;
		start_errors = error_count;
		program_q.delete();
		emit(lisp_pkg::OP_PUSH, 16'h0001);
		emit(lisp_pkg::OP_GOTO, 16'h0000);
		load_and_hold_reset();
		release_reset();
		@(negedge clk);
		check_value("instr_address after reset", instr_address, 0);
		check_value("data_write_enable after reset", data_write_enable, 0);
		wait_for_loop("reset_and_fetch");
		report_test("reset_and_fetch", start_errors);
	endtask

	task automatic run_alu_tests();
		lisp_pkg::opcode_t alu_ops [11] = '{lisp_pkg::OP_ADD, lisp_pkg::OP_SUB,
			lisp_pkg::OP_GTR, lisp_pkg::OP_GTE, lisp_pkg::OP_EQ, lisp_pkg::OP_NEQ,
			lisp_pkg::OP_AND, lisp_pkg::OP_OR, lisp_pkg::OP_XOR, lisp_pkg::OP_LSHIFT,
			lisp_pkg::OP_RSHIFT};
		lisp_pkg::opcode_t op;
		lisp_pkg::word_t   tos;
		lisp_pkg::word_t   nos;
		int                start_errors;
		start_errors = error_count;
		// Second round uses equal operands for the comparisons
		for (int round = 0; round < 2; round++)
		begin
			for (int i = 0; i < 11; i++)
			begin
				op = alu_ops[i];
				tos = lisp_pkg::word_t'($urandom);
				nos = (round == 1) ? tos : lisp_pkg::word_t'($urandom);
				if (op == lisp_pkg::OP_LSHIFT || op == lisp_pkg::OP_RSHIFT)
					nos = nos & 16'h000f;
				program_q.delete();
				emit(lisp_pkg::OP_PUSH, nos);
				emit(lisp_pkg::OP_PUSH, tos);
				emit(op, 16'h0000);
				emit(lisp_pkg::OP_PUSH, 16'h0100);
				emit(lisp_pkg::OP_STORE, 16'h0000);
				emit(lisp_pkg::OP_GOTO, 16'h0000);
				run_program("alu_operations");
				check_memory(16'h0100, expected_alu(op, tos, nos));
			end
		end
		report_test("alu_operations", start_errors);
	endtask

	task automatic run_stack_test();
		lisp_pkg::word_t model [$];
		lisp_pkg::word_t value;
		int unsigned     choice;
		int              depth;
		int              start_errors;
		start_errors = error_count;
		program_q.delete();
		for (int i = 0; i < 14; i++)
		begin
			// 0 pushes, 1 duplicates, 2 pops
			choice = $urandom_range(0, 2);
			if (model.size() == 0)
				choice = 0;
			else if (choice == 2 && model.size() < 2)
				choice = 1;
			case (choice)
				0:
				begin
					value = lisp_pkg::word_t'($urandom);
					emit(lisp_pkg::OP_PUSH, value);
					model.push_back(value);
				end
				1:
				begin
					emit(lisp_pkg::OP_DUP, 16'h0000);
					model.push_back(model[$]);
				end
				default:
				begin
					emit(lisp_pkg::OP_POP, 16'h0000);
					void'(model.pop_back());
				end
			endcase
		end
		depth = model.size();
		// Store the top entry, then pop it, down to the bottom
		for (int i = 0; i < depth; i++)
		begin
			emit(lisp_pkg::OP_PUSH, lisp_pkg::imm_t'(16'h0200 + i));
			emit(lisp_pkg::OP_STORE, 16'h0000);
			emit(lisp_pkg::OP_POP, 16'h0000);
		end
		emit(lisp_pkg::OP_GOTO, 16'h0000);
		run_program("stack_operations");
		for (int i = 0; i < depth; i++)
			check_memory(lisp_pkg::addr_t'(16'h0200 + i), model[depth - 1 - i]);
		report_test("stack_operations", start_errors);
	endtask

	task automatic run_memory_test();
		lisp_pkg::word_t value;
		lisp_pkg::addr_t first;
		lisp_pkg::addr_t second;
		int              start_errors;
		start_errors = error_count;
		for (int i = 0; i < 3; i++)
		begin
			value = lisp_pkg::word_t'($urandom);
			first = lisp_pkg::addr_t'($urandom_range(16'h0200, 16'h0fff));
			second = first + 16'h1000;
			program_q.delete();
			emit(lisp_pkg::OP_PUSH, value);
			emit(lisp_pkg::OP_PUSH, first);
			emit(lisp_pkg::OP_STORE, 16'h0000);
			// NOS under the LOAD address differs from the stored value
			emit(lisp_pkg::OP_PUSH, ~value);
			emit(lisp_pkg::OP_PUSH, first);
			emit(lisp_pkg::OP_LOAD, 16'h0000);
			emit(lisp_pkg::OP_PUSH, second);
			emit(lisp_pkg::OP_STORE, 16'h0000);
			emit(lisp_pkg::OP_GOTO, 16'h0000);
			run_program("memory_access");
			check_memory(first, value);
			check_memory(second, value);
		end
		report_test("memory_access", start_errors);
	endtask

	task automatic store_marker(input lisp_pkg::word_t marker, input lisp_pkg::addr_t address);
		emit(lisp_pkg::OP_PUSH, marker);
		emit(lisp_pkg::OP_PUSH, address);
		emit(lisp_pkg::OP_STORE, 16'h0000);
	endtask

	task automatic run_branch_test();
		int start_errors;
		start_errors = error_count;
		program_q.delete();
		// Offsets count from the branch itself
		emit(lisp_pkg::OP_PUSH, 16'h0000);
		emit(lisp_pkg::OP_BFALSE, 16'h0004);
		store_marker(16'hbad0, 16'h0300);
		store_marker(16'h600d, 16'h0301);
		emit(lisp_pkg::OP_PUSH, 16'h0005);
		emit(lisp_pkg::OP_BFALSE, 16'h0004);
		store_marker(16'hf00d, 16'h0302);
		emit(lisp_pkg::OP_GOTO, 16'h0004);
		store_marker(16'hbad1, 16'h0303);
		store_marker(16'h900d, 16'h0304);
		emit(lisp_pkg::OP_GOTO, 16'h0000);
		run_program("branching");
		check_memory(16'h0300, i_tb_memory.data_fill(16'h0300));
		check_memory(16'h0301, 16'h600d);
		check_memory(16'h0302, 16'hf00d);
		check_memory(16'h0303, i_tb_memory.data_fill(16'h0303));
		check_memory(16'h0304, 16'h900d);
		report_test("branching", start_errors);
	endtask

	initial
	begin
		rst_n = 1'b0;
		error_count = 0;
		tests_run = 0;
		tests_failed = 0;
		void'($urandom(32'hae23_658f));
		run_reset_test();
		run_alu_tests();
		run_stack_test();
		run_memory_test();
		run_branch_test();
		$display("tests run %0d, failing tests %0d, check errors %0d",
			tests_run, tests_failed, error_count);
		if (error_count == 0)
		begin
			$display("all tests passed");
		end
		else
		begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: lisp_core.f
lisp_pkg.sv
stack_alu.sv
core_control.sv
core_datapath.sv
lisp_core.sv
tb_memory.sv
tb_lisp_core.sv

// File: Bender.yml
package:
  name: lisp_core

sources:
  - lisp_pkg.sv
  - stack_alu.sv
  - core_control.sv
  - core_datapath.sv
  - lisp_core.sv
  - target: test
    files:
      - tb_memory.sv
      - tb_lisp_core.sv
